// File: build.f
logic/alut_pkg.sv
logic/alut_mem.sv
logic/alut_age_checker.sv
logic/alut_addr_checker.sv
logic/alut_top.sv
sim/alut_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the address lookup testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f build.f --top-module alut_tb -o alut_sim
if [ $? -ne 0 ]; then
   echo "run_sim: verilator build failed"
   exit 1
fi

./obj_dir/alut_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "run_sim: simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
   exit 0
fi
echo "run_sim: pass line not found in sim.log"
exit 1

// File: sim/alut_tb.sv
`timescale 1ns/1ps

module alut_tb;

   // --------------------
   // stations, hash is the xor of the six bytes

   localparam logic [47:0] MAC_ADDR = 48'h02_00_00_00_00_fe;   // own address, hash fc
   localparam logic [47:0] STA_A    = 48'h02_00_00_00_00_11;   // hash 13
   localparam logic [47:0] STA_B    = 48'h02_00_00_00_00_22;   // hash 20
   localparam logic [47:0] STA_C    = 48'h02_00_00_00_00_33;   // hash 31
   localparam logic [47:0] STA_D    = 48'h02_00_00_00_11_00;   // hash 13, same slot as a
   localparam logic [47:0] STA_E    = 48'h02_00_00_00_00_44;   // hash 46

   // one check per row
   typedef struct packed {
      logic [7:0]  ticks;         // time ticks before the check
      logic [47:0] d_addr;
      logic [47:0] s_addr;
      logic [1:0]  s_port;
      logic        clr;           // clear_reused pulse before the check
      logic [4:0]  exp_dport;
      logic        exp_reused;
      logic [47:0] exp_inv_addr;
      logic [1:0]  exp_inv_port;
   } row_t;

   logic                pclk11;
   logic                n_p_reset11;
   alut_pkg::alut_cmd_e command;
   logic [47:0]         mac_addr;
   logic [47:0]         d_addr;
   logic [47:0]         s_addr;
   logic [1:0]          s_port;
   logic                time_tick;
   logic                clear_reused;
   logic [4:0]          d_port;
   logic                add_check_active;
   logic                reused;
   logic [47:0]         lst_inv_addr;
   logic [1:0]          lst_inv_port;

   row_t        rows[$];
   logic [31:0] rnd_state;
   int          errors = 0;
   int          checks = 0;
   int          cycle_cnt = 0;
   int          cycle_limit = 0;   // set once the table is built
   int          total_ticks = 0;

   alut_top alut_top_inst (
      .pclk11           (pclk11),
      .n_p_reset11      (n_p_reset11),
      .command          (command),
      .mac_addr         (mac_addr),
      .d_addr           (d_addr),
      .s_addr           (s_addr),
      .s_port           (s_port),
      .time_tick        (time_tick),
      .clear_reused     (clear_reused),
      .d_port           (d_port),
      .add_check_active (add_check_active),
      .reused           (reused),
      .lst_inv_addr     (lst_inv_addr),
      .lst_inv_port     (lst_inv_port)
   );

   initial
   begin
      pclk11 = 1'b0;
      forever #2 pclk11 = ~pclk11;   // 4 ns period
   end

   // --------------------
   // helpers

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rnd_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rnd_state = x;
      return x;
   endfunction

   task automatic add_row(input int ticks, input logic [47:0] da, input logic [47:0] sa,
                          input logic [1:0] sp, input logic clr, input logic [4:0] dport,
                          input logic rsd, input logic [47:0] ia, input logic [1:0] ip);
      row_t r;
      r.ticks        = 8'(ticks);
      r.d_addr       = da;
      r.s_addr       = sa;
      r.s_port       = sp;
      r.clr          = clr;
      r.exp_dport    = dport;
      r.exp_reused   = rsd;
      r.exp_inv_addr = ia;
      r.exp_inv_port = ip;
      rows.push_back(r);
   endtask

   task automatic check_field(input string what, input int idx, input logic [47:0] got,
                              input logic [47:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAIL at %0t ns: row %0d %s got %h expected %h", $time, idx, what, got, exp);
      end
   endtask

   // expected ports worked out by hand, flood is 1111 minus the rx port
   task automatic build_table();
      add_row(0,  MAC_ADDR, STA_A, 2'd0, 1'b0, 5'b1_0000, 1'b0, 48'h0, 2'd0);  // for the switch
      add_row(0,  STA_A, STA_B, 2'd1, 1'b0, 5'b0_1101, 1'b0, 48'h0, 2'd0);     // a never learned
      add_row(0,  STA_B, STA_C, 2'd2, 1'b0, 5'b0_0010, 1'b0, 48'h0, 2'd0);     // b on port 1
      add_row(0,  STA_C, STA_E, 2'd2, 1'b0, 5'b0_0000, 1'b0, 48'h0, 2'd0);     // same port as c
      add_row(0,  STA_B, STA_A, 2'd3, 1'b0, 5'b0_0010, 1'b0, 48'h0, 2'd0);     // a learned port 3
      add_row(16, STA_B, STA_C, 2'd2, 1'b0, 5'b0_1011, 1'b0, 48'h0, 2'd0);     // b aged out
      add_row(0,  STA_C, STA_A, 2'd3, 1'b0, 5'b0_0100, 1'b0, 48'h0, 2'd0);     // c refreshed
      add_row(0,  STA_E, STA_B, 2'd1, 1'b0, 5'b0_1101, 1'b0, 48'h0, 2'd0);     // e stale, b refresh
      add_row(0,  STA_B, STA_C, 2'd0, 1'b0, 5'b0_0010, 1'b0, 48'h0, 2'd0);     // b back again
      add_row(15, STA_A, STA_B, 2'd1, 1'b0, 5'b0_1000, 1'b0, 48'h0, 2'd0);     // age 15, in date
      add_row(0,  STA_B, STA_D, 2'd0, 1'b0, 5'b0_0010, 1'b1, STA_A, 2'd3);     // d evicts a
      add_row(0,  STA_A, STA_C, 2'd0, 1'b0, 5'b0_1110, 1'b1, STA_A, 2'd3);     // slot holds d
      add_row(0,  STA_D, STA_B, 2'd1, 1'b1, 5'b0_0001, 1'b0, STA_A, 2'd3);     // cleared, kept
      add_row(0,  MAC_ADDR, STA_A, 2'd2, 1'b0, 5'b1_0000, 1'b0, STA_A, 2'd3);
      add_row(0,  STA_A, STA_B, 2'd1, 1'b0, 5'b0_1101, 1'b0, STA_A, 2'd3);     // a not relearned
   endtask

   // --------------------
   // one check: gap, ticks, optional clear, command, wait, compare

   task automatic apply_row(input int idx);
      row_t        r;
      logic [31:0] rv;
      int          gap;
      int          len;
      r   = rows[idx];
      rv  = next_rand();
      gap = int'(rv[1:0]);   // 0 to 3 idle cycles
      repeat (gap) @(negedge pclk11);
      d_addr = r.d_addr;     // held until the check is done
      s_addr = r.s_addr;
      s_port = r.s_port;
      repeat (int'(r.ticks))
      begin
         time_tick = 1'b1;
         @(negedge pclk11);
      end
      time_tick = 1'b0;
      if (r.clr)
      begin
         clear_reused = 1'b1;
         @(negedge pclk11);
         clear_reused = 1'b0;
      end
      command = alut_pkg::cmd_check;
      @(negedge pclk11);
      command = alut_pkg::cmd_none;
      len = 0;
      while (add_check_active)   // watchdog covers a stuck fsm
      begin
         len++;
         @(negedge pclk11);
      end
      // 1 cycle for the own address, 9 for a full lookup and learn
      check_field("active cycles", idx, 48'(len), (r.d_addr == MAC_ADDR) ? 48'd1 : 48'd9);
      check_field("d_port", idx, 48'(d_port), 48'(r.exp_dport));
      check_field("reused", idx, 48'(reused), 48'(r.exp_reused));
      check_field("lst_inv_addr", idx, lst_inv_addr, r.exp_inv_addr);
      check_field("lst_inv_port", idx, 48'(lst_inv_port), 48'(r.exp_inv_port));
   endtask

   // --------------------
   // watchdog

   initial
   begin
      wait (cycle_limit != 0);
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge pclk11);
         cycle_cnt++;
      end
      $display("timeout: the run hit %0d cycles before the stimulus table was done", cycle_cnt);
      $display("checks %0d, errors %0d, timeouts 1", checks, errors);
      $display("Result: FAILED");
      $finish;
   end

   // --------------------
   // main sequence

   initial
   begin
      command      = alut_pkg::cmd_none;
      mac_addr     = MAC_ADDR;
      d_addr       = '0;
      s_addr       = '0;
      s_port       = '0;
      time_tick    = 1'b0;
      clear_reused = 1'b0;
      n_p_reset11  = 1'b0;
      rnd_state    = 32'hc583_9227;

      build_table();
      foreach (rows[i])
         total_ticks += int'(rows[i].ticks);
      cycle_limit = rows.size() * 20 + total_ticks + 100;

      repeat (8) @(negedge pclk11);
      n_p_reset11 = 1'b1;
      @(negedge pclk11);
      check_field("d_port after reset", -1, 48'(d_port), 48'(5'b0_1111));
      check_field("add_check_active after reset", -1, 48'(add_check_active), 48'd0);
      check_field("reused after reset", -1, 48'(reused), 48'd0);

      foreach (rows[i])
         apply_row(i);

      $display("checks %0d, errors %0d, timeouts 0", checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: logic/alut_top.sv
`timescale 1ns/1ps

module alut_top
#(
   parameter int unsigned MAX_AGE = 16
)
(
   input  logic                  pclk11,
   input  logic                  n_p_reset11,
   input  alut_pkg::alut_cmd_e   command,
   input  logic [47:0]           mac_addr,
   input  logic [47:0]           d_addr,
   input  logic [47:0]           s_addr,
   input  logic [1:0]            s_port,
   input  logic                  time_tick,
   input  logic                  clear_reused,
   output logic [4:0]            d_port,
   output logic                  add_check_active,
   output logic                  reused,
   output logic [47:0]           lst_inv_addr,
   output logic [1:0]            lst_inv_port
);

   // --------------------
   // checker to memory
   logic [alut_pkg::ALUT_IDX_W-1:0] mem_addr;
   logic                            mem_write;
   logic [alut_pkg::ENTRY_W-1:0]    mem_wdata;
   logic [alut_pkg::ENTRY_W-1:0]    mem_rdata;

   // checker to age checker
   logic                            check_age;
   logic [alut_pkg::TIME_W-1:0]     last_accessed;
   logic [alut_pkg::TIME_W-1:0]     curr_time;
   logic                            age_confirmed;
   logic                            age_ok;

   alut_addr_checker alut_addr_checker_inst (
      .pclk11           (pclk11),
      .n_p_reset11      (n_p_reset11),
      .command          (command),
      .mac_addr         (mac_addr),
      .d_addr           (d_addr),
      .s_addr           (s_addr),
      .s_port           (s_port),
      .curr_time        (curr_time),
      .mem_rdata        (mem_rdata),
      .age_confirmed    (age_confirmed),
      .age_ok           (age_ok),
      .clear_reused     (clear_reused),
      .d_port           (d_port),
      .add_check_active (add_check_active),
      .mem_addr         (mem_addr),
      .mem_write        (mem_write),
      .mem_wdata        (mem_wdata),
      .check_age        (check_age),
      .last_accessed    (last_accessed),
      .reused           (reused),
      .lst_inv_addr     (lst_inv_addr),
      .lst_inv_port     (lst_inv_port)
   );

   alut_age_checker #(.MAX_AGE(MAX_AGE)) alut_age_checker_inst (
      .pclk11        (pclk11),
      .n_p_reset11   (n_p_reset11),
      .time_tick     (time_tick),
      .check_age     (check_age),
      .last_accessed (last_accessed),
      .curr_time     (curr_time),
      .age_confirmed (age_confirmed),
      .age_ok        (age_ok)
   );

   alut_mem alut_mem_inst (
      .pclk11      (pclk11),
      .n_p_reset11 (n_p_reset11),
      .mem_addr    (mem_addr),
      .mem_write   (mem_write),
      .mem_wdata   (mem_wdata),
      .mem_rdata   (mem_rdata)
   );

endmodule

// File: logic/alut_addr_checker.sv
`timescale 1ns/1ps

module alut_addr_checker
(
   input  logic                                  pclk11,
   input  logic                                  n_p_reset11,
   input  alut_pkg::alut_cmd_e                   command,
   input  logic [47:0]                           mac_addr,      // own switch address
   input  logic [47:0]                           d_addr,
   input  logic [47:0]                           s_addr,
   input  logic [1:0]                            s_port,
   input  logic [alut_pkg::TIME_W-1:0]           curr_time,
   input  logic [alut_pkg::ENTRY_W-1:0]          mem_rdata,
   input  logic                                  age_confirmed,
   input  logic                                  age_ok,
   input  logic                                  clear_reused,
   output logic [4:0]                            d_port,
   output logic                                  add_check_active,
   output logic [alut_pkg::ALUT_IDX_W-1:0]       mem_addr,
   output logic                                  mem_write,
   output logic [alut_pkg::ENTRY_W-1:0]          mem_wdata,
   output logic                                  check_age,
   output logic [alut_pkg::TIME_W-1:0]           last_accessed,
   output logic                                  reused,
   output logic [47:0]                           lst_inv_addr,
   output logic [1:0]                            lst_inv_port
);

   alut_pkg::chk_state_e state;
   alut_pkg::chk_state_e nxt_state;

   logic [alut_pkg::ALUT_IDX_W-1:0] s_hash;          // learn index
   logic [alut_pkg::ALUT_IDX_W-1:0] d_hash;          // lookup index
   logic                            age_entry;       // first cycle of age_chk
   logic                            dest_hit;        // dest entry still usable
   logic [3:0]                      port_onehot;
   logic [3:0]                      src_mask;
   logic [3:0]                      flood_mask;
   logic [47:0]                     rd_addr;
   logic                            rd_valid;

   // --------------------
   // hashes and read field split

   assign s_hash = s_addr[7:0] ^ s_addr[15:8] ^ s_addr[23:16] ^
                   s_addr[31:24] ^ s_addr[39:32] ^ s_addr[47:40];
   assign d_hash = d_addr[7:0] ^ d_addr[15:8] ^ d_addr[23:16] ^
                   d_addr[31:24] ^ d_addr[39:32] ^ d_addr[47:40];

   assign rd_valid    = mem_rdata[alut_pkg::ENTRY_VALID_BIT];
   assign rd_addr     = mem_rdata[alut_pkg::ENTRY_PORT_LSB-1:0];
   assign port_onehot = 4'b0001 << mem_rdata[alut_pkg::ENTRY_PORT_LSB +: 2];
   assign src_mask    = 4'b0001 << s_port;   // never send back out the rx port
   assign flood_mask  = 4'b1111 & ~src_mask;

   // --------------------
   // check and learn FSM

   always_comb
   begin
      case (state)
         alut_pkg::st_idle:
            if (command == alut_pkg::cmd_check)
               nxt_state = alut_pkg::st_mac_chk;
            else
               nxt_state = alut_pkg::st_idle;
         alut_pkg::st_mac_chk:
            if (d_addr == mac_addr)
               nxt_state = alut_pkg::st_idle;      // frame for the switch itself
            else
               nxt_state = alut_pkg::st_read_dest;
         alut_pkg::st_read_dest: nxt_state = alut_pkg::st_valid_chk;
         alut_pkg::st_valid_chk: nxt_state = alut_pkg::st_age_chk;
         alut_pkg::st_age_chk:
            if (age_confirmed)
               nxt_state = alut_pkg::st_addr_chk;
            else
               nxt_state = alut_pkg::st_age_chk;   // wait for the age answer
         alut_pkg::st_addr_chk:  nxt_state = alut_pkg::st_read_src;
         alut_pkg::st_read_src:  nxt_state = alut_pkg::st_write_src;
         alut_pkg::st_write_src: nxt_state = alut_pkg::st_idle;
         default:                nxt_state = alut_pkg::st_idle;
      endcase
   end

   always_ff @(posedge pclk11 or negedge n_p_reset11)
   begin
      if (!n_p_reset11)
         state <= alut_pkg::st_idle;
      else
         state <= nxt_state;
   end

   assign add_check_active = (state != alut_pkg::st_idle);   // status bit

   // --------------------
   // memory addressing
   // dest hash until the age answer, then source hash for read_src and the write

   always_ff @(posedge pclk11 or negedge n_p_reset11)
   begin
      if (!n_p_reset11)
      begin
         mem_addr  <= '0;
         mem_write <= 1'b0;
      end
      else
      begin
         if ((nxt_state == alut_pkg::st_addr_chk) || (nxt_state == alut_pkg::st_read_src) ||
             (nxt_state == alut_pkg::st_write_src))
            mem_addr <= s_hash;
         else
            mem_addr <= d_hash;
         mem_write <= (nxt_state == alut_pkg::st_write_src);   // write lands leaving write_src
      end
   end

   // learned entries are always valid
   assign mem_wdata = {1'b1, curr_time, s_port, s_addr};

   // --------------------
   // age request, pulse in the second age_chk cycle

   always_ff @(posedge pclk11 or negedge n_p_reset11)
   begin
      if (!n_p_reset11)
      begin
         age_entry <= 1'b0;
         check_age <= 1'b0;
      end
      else
      begin
         age_entry <= (state == alut_pkg::st_valid_chk);
         check_age <= age_entry;
      end
   end

   always_ff @(posedge pclk11)
   begin
      if (age_entry)
         last_accessed <= mem_rdata[alut_pkg::ENTRY_TIME_LSB +: alut_pkg::TIME_W];
   end

   // --------------------
   // port decision

   always_ff @(posedge pclk11 or negedge n_p_reset11)
   begin
      if (!n_p_reset11)
      begin
         dest_hit <= 1'b0;
         d_port   <= 5'b0_1111;
      end
      else
      begin
         if (state == alut_pkg::st_valid_chk)
            dest_hit <= rd_valid;                       // empty slot means flood
         else if ((state == alut_pkg::st_age_chk) && age_confirmed)
            dest_hit <= dest_hit & age_ok;              // stale entry means flood

         if ((state == alut_pkg::st_mac_chk) && (d_addr == mac_addr))
            d_port <= 5'b1_0000;
         else if (state == alut_pkg::st_addr_chk)
         begin
            if (dest_hit && (rd_addr == d_addr))
               d_port <= {1'b0, port_onehot & ~src_mask};
            else
               d_port <= {1'b0, flood_mask};            // miss or collision
         end
      end
   end

   // --------------------
   // reused tracking on the overwritten slot

   always_ff @(posedge pclk11 or negedge n_p_reset11)
   begin
      if (!n_p_reset11)
      begin
         reused       <= 1'b0;
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if ((state == alut_pkg::st_read_src) && rd_valid && (rd_addr != s_addr))
      begin
         reused       <= 1'b1;
         lst_inv_addr <= rd_addr;
         lst_inv_port <= mem_rdata[alut_pkg::ENTRY_PORT_LSB +: 2];
      end
      else if (clear_reused)
         reused <= 1'b0;   // lost address and port stay readable
   end

   // switch address and an ethernet port are never both selected
   a_dport_excl: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
      !(d_port[4] && (|d_port[3:0])));

   // write strobe only ever sits on the cycle that follows read_src
   a_write_slot: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
      mem_write |-> (state == alut_pkg::st_write_src) &&
                    $past(state == alut_pkg::st_read_src));

endmodule

// File: logic/alut_age_checker.sv
`timescale 1ns/1ps

module alut_age_checker
#(
   parameter int unsigned MAX_AGE = 16   // ticks before an entry goes stale
)
(
   input  logic                          pclk11,
   input  logic                          n_p_reset11,
   input  logic                          time_tick,      // one-cycle strobe
   input  logic                          check_age,      // request pulse
   input  logic [alut_pkg::TIME_W-1:0]   last_accessed,
   output logic [alut_pkg::TIME_W-1:0]   curr_time,
   output logic                          age_confirmed,
   output logic                          age_ok
);

   logic [alut_pkg::TIME_W-1:0] age_diff;   // elapsed ticks mod 2^32

   // --------------------
   // time base

   always_ff @(posedge pclk11 or negedge n_p_reset11)
   begin
      if (!n_p_reset11)
         curr_time <= '0;
      else if (time_tick)
         curr_time <= curr_time + 1'b1;   // wraps at 32 bits
   end

   assign age_diff = curr_time - last_accessed;

   // --------------------
   // in-date answer one cycle after the request

   always_ff @(posedge pclk11 or negedge n_p_reset11)
   begin
      if (!n_p_reset11)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else
      begin
         age_confirmed <= check_age;
         if (check_age)
            age_ok <= (age_diff < MAX_AGE);   // level held until next request
      end
   end

   // one answer per single-cycle request
   a_age_answer: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
      age_confirmed |-> $past(check_age) && !$past(check_age, 2));

endmodule

// File: logic/alut_mem.sv
`timescale 1ns/1ps

module alut_mem
(
   input  logic                                pclk11,
   input  logic                                n_p_reset11,
   input  logic [alut_pkg::ALUT_IDX_W-1:0]     mem_addr,
   input  logic                                mem_write,
   input  logic [alut_pkg::ENTRY_W-1:0]        mem_wdata,
   output logic [alut_pkg::ENTRY_W-1:0]        mem_rdata
);

   localparam int DEPTH = 1 << alut_pkg::ALUT_IDX_W;

   logic [alut_pkg::ENTRY_VALID_BIT-1:0] mem_data [DEPTH];   // time, port, addr
   logic [DEPTH-1:0]                     valid_vec;         // one flag per slot
   logic [alut_pkg::ENTRY_VALID_BIT-1:0] rd_data;
   logic                                 rd_valid;

   // --------------------
   // valid flags, cleared by reset

   always_ff @(posedge pclk11 or negedge n_p_reset11)
   begin
      if (!n_p_reset11)
      begin
         valid_vec <= '0;
         rd_valid  <= 1'b0;
      end
      else
      begin
         if (mem_write)
            valid_vec[mem_addr] <= mem_wdata[alut_pkg::ENTRY_VALID_BIT];
         rd_valid <= valid_vec[mem_addr];   // old value on a same-cycle write
      end
   end

   // entry payload array
   always_ff @(posedge pclk11)
   begin
      if (mem_write)
         mem_data[mem_addr] <= mem_wdata[alut_pkg::ENTRY_VALID_BIT-1:0];
      rd_data <= mem_data[mem_addr];   // registered read
   end

   assign mem_rdata = {rd_valid, rd_data};

   // a write to an unknown slot would corrupt the table
   a_wr_addr_known: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
      mem_write |-> !$isunknown(mem_addr));

endmodule

// File: logic/alut_pkg.sv
package alut_pkg;

   // --------------------
   // table geometry

   localparam int ALUT_IDX_W      = 8;    // 256 entries, byte-xor hash
   localparam int ENTRY_W         = 83;   // valid + time + port + addr
   localparam int ENTRY_VALID_BIT = 82;
   localparam int ENTRY_TIME_LSB  = 50;   // time field is TIME_W wide
   localparam int ENTRY_PORT_LSB  = 48;   // port field is 2 bits, addr sits below it
   localparam int TIME_W          = 32;

   // --------------------
   // address checker states, walked in this order

   typedef enum logic [2:0] {
      st_idle      = 3'd0,
      st_mac_chk   = 3'd1,    // destination vs own switch address
      st_read_dest = 3'd2,    // dest entry on the read port
      st_valid_chk = 3'd3,
      st_age_chk   = 3'd4,    // entry, request, confirm
      st_addr_chk  = 3'd5,
      st_read_src  = 3'd6,    // entry about to be overwritten
      st_write_src = 3'd7
   } chk_state_e;

   // command opcodes, only check is acted on
   typedef enum logic [1:0] {
      cmd_none   = 2'b00,
      cmd_check  = 2'b01,
      cmd_rsvd_2 = 2'b10,
      cmd_rsvd_3 = 2'b11
   } alut_cmd_e;

endpackage
